// File: soc_glue_golden.txt
// 0-3 buffer words, 4 word written outside region 7, 5-7 frame lengths
// 8-15 receive words {last, valid, data[7:0]}, 16 expected captured word count
a1b2c3d4
0f1e2d3c
55aa33cc
deadbeef
12345678
10
05
01
15a
0c3
17e
100
2f0
3e5
181
381
06

// File: tb.f
soc_glue_pkg.sv
sys_reset_ctrl.sv
heartbeat_led.sv
udp_tx_engine.sv
rx_cdc_fifo.sv
soc_glue_top.sv
tb_soc_glue_assertions.sv
tb_soc_glue.sv

// File: Bender.yml
package:
  name: soc_glue

sources:
  - soc_glue_pkg.sv
  - sys_reset_ctrl.sv
  - heartbeat_led.sv
  - udp_tx_engine.sv
  - rx_cdc_fifo.sv
  - soc_glue_top.sv
  - target: simulation
    files:
      - tb_soc_glue_assertions.sv
      - tb_soc_glue.sv

// File: tb_soc_glue.sv
module tb_soc_glue import soc_glue_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HB_TICKS = 9;
    localparam int HOLD     = 4;
    localparam int GOLD_N   = 17;
    localparam int G_STRAY  = 4;   // word written outside region 7
    localparam int G_LEN    = 5;   // first frame length
    localparam int N_LEN    = 3;
    localparam int G_RX     = 8;   // first receive word
    localparam int N_RX     = 8;
    localparam int G_RX_CNT = 16;  // expected number of captured words

    logic        HCLK;
    logic        rx_clk;
    logic        rst_key;
    logic        ddr_init_done;
    logic        watchdog_reset;
    logic        sys_reset_req;
    logic [1:0]  gpio_out;
    logic [1:0]  gpio_outen;
    logic [3:0]  led;
    ahb_req_t    ahb_req;
    ahb_rsp_t    ahb_rsp;
    mac_tx_t     core_tx;
    logic        core_tx_hold;
    logic        mac_tpnd;
    mac_tx_t     mac_tx;
    mac_rx_t     mac_rx;
    mac_rx_t     core_rx;
    logic        spi_clk;
    logic        spi_mosi;
    logic [1:0]  spi_cs;
    logic        spi_miso;
    logic        spi0_clk;
    logic        spi0_mosi;
    logic        spi0_cs;
    logic        spi0_miso;
    logic        spi1_clk;
    logic        spi1_mosi;
    logic        spi1_cs;
    logic        spi1_miso;
    logic        scl_in;
    logic        sda_in;
    logic        scl_drv;
    logic        sda_drv;
    tri1         i2c_scl;      // pad pull-ups
    tri1         i2c_sda;
    logic [31:0] gold [GOLD_N];
    int          errors;
    int          checks;
    int          seed = 32'h5d263b67;

    soc_glue_top #(
        .HEARTBEAT_TICKS (HB_TICKS),
        .RESET_HOLD      (HOLD)
    ) UUT (
        .HCLK (HCLK), .rst_key (rst_key), .rx_clk_i (rx_clk),
        .ddr_init_done_i (ddr_init_done), .watchdog_reset_i (watchdog_reset),
        .sys_reset_req_i (sys_reset_req), .gpio_out_i (gpio_out),
        .gpio_outen_i (gpio_outen), .led_o (led), .ahb_i (ahb_req), .ahb_o (ahb_rsp),
        .core_tx_i (core_tx), .core_tx_hold_o (core_tx_hold), .mac_tpnd_i (mac_tpnd),
        .mac_tx_o (mac_tx), .mac_rx_i (mac_rx), .core_rx_o (core_rx),
        .spi_clk_i (spi_clk), .spi_mosi_i (spi_mosi), .spi_cs_i (spi_cs),
        .spi_miso_o (spi_miso), .spi0_clk_o (spi0_clk), .spi0_mosi_o (spi0_mosi),
        .spi0_cs_o (spi0_cs), .spi0_miso_i (spi0_miso), .spi1_clk_o (spi1_clk),
        .spi1_mosi_o (spi1_mosi), .spi1_cs_o (spi1_cs), .spi1_miso_i (spi1_miso),
        .i2c_scl_io (i2c_scl), .i2c_sda_io (i2c_sda),
        .scl_i_o (scl_in), .sda_i_o (sda_in), .scl_o_i (scl_drv), .sda_o_i (sda_drv)
    );

    initial begin
        HCLK = 1'b0;
        forever #20 HCLK = ~HCLK;
    end

    initial begin
        rx_clk = 1'b0;
        forever #28 rx_clk = ~rx_clk;
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("ERROR: timed out waiting for %s", what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_start);
        $display("test %-10s done, %0d error(s)", name, errors - err_start);
    endtask

    task automatic drive_addr_phase(input addr_t addr, input logic wr);
        @(negedge HCLK);
        ahb_req.sel   = 1'b1;
        ahb_req.trans = 2'b10;    // NONSEQ
        ahb_req.write = wr;
        ahb_req.size  = 3'b010;
        ahb_req.addr  = addr;
    endtask

    task automatic ahb_write(input addr_t addr, input word_t data);
        drive_addr_phase(addr, 1'b1);
        @(negedge HCLK);
        ahb_req.sel   = 1'b0;
        ahb_req.trans = 2'b00;
        ahb_req.wdata = data;     // data phase
    endtask

    task automatic ahb_read(input addr_t addr, output word_t data);
        drive_addr_phase(addr, 1'b0);
        @(negedge HCLK);
        data = ahb_rsp.rdata;
        compare_value("ahb okay", 32'h2, {ahb_rsp.readyout, ahb_rsp.resp});
        ahb_req.sel   = 1'b0;
        ahb_req.trans = 2'b00;
    endtask

    task automatic reset_test();
        int    err0;
        int    n;
        word_t rd;
        err0 = errors;
        repeat (3) @(negedge HCLK);
        compare_value("led reset", 1, led[3]);
        rst_key = 1'b1;
        for (int i = 0; i < 4; i++) begin
            @(negedge HCLK);
            compare_value("rst held", 0, UUT.sys_rst_n);   // no init done yet
            compare_value("cs reset", 0, UUT.udp_cs);
            compare_value("tx strobes", 0, {mac_tx.start, mac_tx.last});
            compare_value("led init low", 0, led[2]);
        end
        ddr_init_done = 1'b1;
        n = 0;
        while (UUT.sys_rst_n !== 1'b1 && n < 10) begin
            @(negedge HCLK);
            n++;
        end
        if (UUT.sys_rst_n !== 1'b1) report_timeout("system reset release");
        compare_value("release delay", 2, n);
        @(negedge HCLK);
        watchdog_reset = 1'b1;
        @(negedge HCLK);
        watchdog_reset = 1'b0;
        n = 0;
        while (UUT.sys_rst_n !== 1'b0 && n < 10) begin
            @(negedge HCLK);
            n++;
        end
        if (UUT.sys_rst_n !== 1'b0) report_timeout("watchdog reset");
        fork
            begin
                n = 0;
                while (UUT.sys_rst_n === 1'b0 && n < 20) begin
                    compare_value("cs in hold", 0, UUT.udp_cs);
                    @(negedge HCLK);
                    n++;
                end
            end
            ahb_write(32'h7000_0010, 32'd16);   // full frame request while held
        join
        compare_value("hold cycles", HOLD, n);
        ahb_read(32'h7000_0014, rd);
        compare_value("busy after hold", 0, rd[0]);
        finish_test("reset", err0);
    endtask

    task automatic heartbeat_test();
        int   err0;
        int   n;
        logic prev;
        err0 = errors;
        prev = led[3];
        n = 0;
        while (led[3] === prev && n < 30) begin
            @(negedge HCLK);
            n++;
        end
        if (led[3] === prev) report_timeout("first led toggle");
        prev = led[3];
        n = 0;
        while (led[3] === prev && n < 30) begin
            @(negedge HCLK);
            n++;
        end
        compare_value("led period", HB_TICKS + 1, n);
        gpio_out   = 2'b11;
        gpio_outen = 2'b10;
        @(posedge HCLK);
        compare_value("led gpio", 2'b10, led[1:0]);   // only bit 1 enabled
        compare_value("led init", ddr_init_done, led[2]);
        finish_test("heartbeat", err0);
    endtask

    task automatic ahb_test();
        int    err0;
        word_t rd;
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            ahb_write(32'h7000_0000 + 4 * i, gold[i]);
        end
        ahb_write(32'h6000_0000, gold[G_STRAY]);    // other region
        for (int i = 0; i < 4; i++) begin
            ahb_read(32'h7000_0000 + 4 * i, rd);
            compare_value("buffer word", gold[i], rd);
        end
        finish_test("ahb", err0);
    endtask

    task automatic send_test();
        int         err0;
        int         n;
        int         beats;
        logic [4:0] len;
        byte_t      exp_b;
        word_t      rd;
        err0 = errors;
        for (int s = 0; s < N_LEN; s++) begin
            len = gold[G_LEN + s][4:0];
            ahb_write(32'h7000_0010, {27'd0, len});
            n = 0;
            while (UUT.udp_cs !== 1'b1 && n < 5) begin
                @(negedge HCLK);
                n++;
            end
            if (UUT.udp_cs !== 1'b1) report_timeout("send start");
            mac_tpnd = 1'b1;          // first beat waits over the status read
            ahb_read(32'h7000_0014, rd);
            compare_value("busy set", 1, rd[0]);
            beats = 0;
            n = 0;
            while (UUT.udp_cs === 1'b1 && n < 200) begin
                mac_tpnd = (($random(seed) & 3) == 0);
                compare_value("tx hold", 1, core_tx_hold);
                if (!mac_tpnd) begin
                    exp_b = gold[beats / 4] >> (8 * (beats % 4));   // little endian
                    compare_value("send data", exp_b, mac_tx.data);
                    compare_value("send start", beats == 0, mac_tx.start);
                    compare_value("send last", beats == len - 1, mac_tx.last);
                    beats++;
                end
                @(negedge HCLK);
                n++;
            end
            mac_tpnd = 1'b0;
            if (UUT.udp_cs === 1'b1) report_timeout("send end");
            compare_value("beat count", len, beats);
            ahb_read(32'h7000_0014, rd);
            compare_value("busy clear", 0, rd[0]);
        end
        finish_test("udp send", err0);
    endtask

    task automatic core_tx_test();
        int err0;
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            @(negedge HCLK);
            core_tx.data  = $random(seed);
            core_tx.start = (i == 0);
            core_tx.last  = (i == 3);
            @(posedge HCLK);
            compare_value("core beat", core_tx, mac_tx);
        end
        @(negedge HCLK);
        core_tx   = '0;
        spi_cs    = 2'b10;          // device 0 selected
        spi_clk   = 1'b1;
        spi_mosi  = 1'b0;
        spi0_miso = 1'b1;
        spi1_miso = 1'b0;
        scl_drv   = 1'b0;
        sda_drv   = 1'b1;
        @(posedge HCLK);
        compare_value("miso cs0", spi0_miso, spi_miso);
        compare_value("spi fanout", 6'b110001,
                      {spi0_clk, spi1_clk, spi0_mosi, spi1_mosi, spi0_cs, spi1_cs});
        compare_value("i2c pads", 4'b0101, {i2c_scl, i2c_sda, scl_in, sda_in});
        @(negedge HCLK);
        spi_cs   = 2'b01;
        spi_clk  = 1'b0;
        spi_mosi = 1'b1;
        scl_drv  = 1'b1;
        sda_drv  = 1'b0;
        @(posedge HCLK);
        compare_value("miso cs1", spi1_miso, spi_miso);
        compare_value("spi fanout", 6'b001110,
                      {spi0_clk, spi1_clk, spi0_mosi, spi1_mosi, spi0_cs, spi1_cs});
        compare_value("i2c pads", 4'b1010, {i2c_scl, i2c_sda, scl_in, sda_in});
        @(negedge HCLK);
        spi_cs  = 2'b11;
        sda_drv = 1'b1;
        finish_test("core tx", err0);
    endtask

    task automatic rx_test();
        int      err0;
        int      n;
        int      got;
        mac_rx_t exp_q [$];
        err0 = errors;
        for (int i = 0; i < N_RX; i++) begin
            if (gold[G_RX + i][8]) exp_q.push_back(gold[G_RX + i][9:0]);
        end
        fork
            begin
                for (int i = 0; i < N_RX; i++) begin
                    @(negedge rx_clk);
                    mac_rx = gold[G_RX + i][9:0];
                end
                @(negedge rx_clk);
                mac_rx = '0;
            end
            begin
                got = 0;
                n = 0;
                while (got < exp_q.size() && n < 150) begin
                    @(negedge HCLK);
                    n++;
                    if (core_rx.valid) begin
                        compare_value("rx word", exp_q[got], core_rx);
                        got++;
                    end
                end
                if (got < exp_q.size()) report_timeout("receive words");
            end
        join
        compare_value("rx count", gold[G_RX_CNT], got);
        repeat (10) begin
            @(negedge HCLK);
            compare_value("rx extra", 0, core_rx.valid);
        end
        finish_test("rx", err0);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst_key = 1'b0;
        ddr_init_done = 1'b0;
        watchdog_reset = 1'b0;
        sys_reset_req = 1'b0;
        gpio_out = 2'b00;
        gpio_outen = 2'b00;
        ahb_req = '0;
        ahb_req.ready = 1'b1;
        core_tx = '0;
        mac_tpnd = 1'b0;
        mac_rx = '0;
        spi_clk = 1'b0;
        spi_mosi = 1'b0;
        spi_cs = 2'b11;
        spi0_miso = 1'b0;
        spi1_miso = 1'b0;
        scl_drv = 1'b1;
        sda_drv = 1'b1;
        $readmemh("soc_glue_golden.txt", gold);
        reset_test();
        heartbeat_test();
        ahb_test();
        send_test();
        core_tx_test();
        rx_test();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tb_soc_glue_assertions.sv
module tb_soc_glue_assertions import soc_glue_pkg::*; (
    input logic    HCLK,
    input logic    rst_n_i,
    input logic    mac_tpnd_i,
    input logic    udp_cs_o,
    input mac_tx_t tx_o
);
    timeunit 1ns;
    timeprecision 1ps;

    beat_held: assert property (@(posedge HCLK) disable iff (!rst_n_i)
        (udp_cs_o && mac_tpnd_i) |=> (udp_cs_o && $stable(tx_o)))
        else $error("transmit beat changed while the mac was pending");

    first_start: assert property (@(posedge HCLK) disable iff (!rst_n_i)
        $rose(udp_cs_o) |-> tx_o.start)
        else $error("first beat of a frame without start");

    // after an accepted middle beat start stays low
    late_start: assert property (@(posedge HCLK) disable iff (!rst_n_i)
        (udp_cs_o && !mac_tpnd_i && !tx_o.last) |=> !tx_o.start)
        else $error("start flag on a later beat");

    // engine goes idle once the last beat is taken
    idle_cs: assert property (@(posedge HCLK) disable iff (!rst_n_i)
        (udp_cs_o && !mac_tpnd_i && tx_o.last) |=> !udp_cs_o)
        else $error("chip select still high after the last beat");

endmodule

bind udp_tx_engine tb_soc_glue_assertions u_tx_assertions (
    .HCLK       (HCLK),
    .rst_n_i    (rst_n_i),
    .mac_tpnd_i (mac_tpnd_i),
    .udp_cs_o   (udp_cs_o),
    .tx_o       (tx_o)
);

// File: soc_glue_top.sv
module soc_glue_top import soc_glue_pkg::*; #(
    parameter int HEARTBEAT_TICKS    = 33_000_000,
    parameter int RESET_HOLD         = 16,
    parameter int RX_FIFO_DEPTH_LOG2 = 4
) (
    input  logic       HCLK,
    input  logic       rst_key,
    input  logic       rx_clk_i,
    input  logic       ddr_init_done_i,
    input  logic       watchdog_reset_i,
    input  logic       sys_reset_req_i,
    input  logic [1:0] gpio_out_i,
    input  logic [1:0] gpio_outen_i,
    output logic [3:0] led_o,
    input  ahb_req_t   ahb_i,
    output ahb_rsp_t   ahb_o,
    input  mac_tx_t    core_tx_i,
    output logic       core_tx_hold_o,
    input  logic       mac_tpnd_i,
    output mac_tx_t    mac_tx_o,
    input  mac_rx_t    mac_rx_i,
    output mac_rx_t    core_rx_o,
    input  logic       spi_clk_i,
    input  logic       spi_mosi_i,
    input  logic [1:0] spi_cs_i,
    output logic       spi_miso_o,
    output logic       spi0_clk_o,
    output logic       spi0_mosi_o,
    output logic       spi0_cs_o,
    input  logic       spi0_miso_i,
    output logic       spi1_clk_o,
    output logic       spi1_mosi_o,
    output logic       spi1_cs_o,
    input  logic       spi1_miso_i,
    inout  wire        i2c_scl_io,
    inout  wire        i2c_sda_io,
    output logic       scl_i_o,
    output logic       sda_i_o,
    input  logic       scl_o_i,
    input  logic       sda_o_i
);

    logic     sys_rst_n;
    logic     heartbeat;
    logic     udp_cs;
    ahb_req_t udp_req;
    mac_tx_t  udp_tx;
    mac_rx_t  rx_word;

    sys_reset_ctrl #(
        .RESET_HOLD       (RESET_HOLD)
    ) u_sys_reset_ctrl (
        .HCLK             (HCLK),
        .rst_key          (rst_key),
        .ddr_init_done_i  (ddr_init_done_i),
        .watchdog_reset_i (watchdog_reset_i),
        .sys_reset_req_i  (sys_reset_req_i),
        .sys_rst_n_o      (sys_rst_n)
    );

    heartbeat_led #(
        .HEARTBEAT_TICKS (HEARTBEAT_TICKS)
    ) u_heartbeat_led (
        .HCLK    (HCLK),
        .rst_key (rst_key),            // blinks during system reset too
        .led_o   (heartbeat)
    );

    assign led_o = {heartbeat, ddr_init_done_i, gpio_out_i & gpio_outen_i};

    // accelerator lives in region 7
    always_comb begin
        udp_req     = ahb_i;
        udp_req.sel = ahb_i.sel & (ahb_i.addr[31:28] == UDP_REGION);
    end

    udp_tx_engine u_udp_tx_engine (
        .HCLK       (HCLK),
        .rst_n_i    (sys_rst_n),
        .ahb_i      (udp_req),
        .ahb_o      (ahb_o),
        .mac_tpnd_i (mac_tpnd_i),
        .tx_o       (udp_tx),
        .udp_cs_o   (udp_cs)
    );

    // mac tx port owned by the engine while it sends
    assign mac_tx_o       = udp_cs ? udp_tx : core_tx_i;
    assign core_tx_hold_o = mac_tpnd_i | udp_cs;

    assign rx_word = mac_rx_i.valid ? mac_rx_i : '0;

    rx_cdc_fifo #(
        .DEPTH_LOG2 (RX_FIFO_DEPTH_LOG2)
    ) u_rx_cdc_fifo (
        .wr_clk_i (rx_clk_i),
        .rd_clk_i (HCLK),
        .rst_n_i  (sys_rst_n),
        .wr_i     (rx_word),
        .rd_o     (core_rx_o)
    );

    // spi fan out, miso from the selected device
    assign spi0_clk_o  = spi_clk_i;
    assign spi1_clk_o  = spi_clk_i;
    assign spi0_mosi_o = spi_mosi_i;
    assign spi1_mosi_o = spi_mosi_i;
    assign spi0_cs_o   = spi_cs_i[0];
    assign spi1_cs_o   = spi_cs_i[1];
    assign spi_miso_o  = !spi_cs_i[0] ? spi0_miso_i :
                         !spi_cs_i[1] ? spi1_miso_i : 1'bz;

    // open drain i2c pads
    assign i2c_scl_io = scl_o_i ? 1'bz : 1'b0;
    assign i2c_sda_io = sda_o_i ? 1'bz : 1'b0;
    assign scl_i_o    = i2c_scl_io;
    assign sda_i_o    = i2c_sda_io;

endmodule

// File: rx_cdc_fifo.sv
module rx_cdc_fifo import soc_glue_pkg::*; #(
    parameter int DEPTH_LOG2 = 4
) (
    input  logic    wr_clk_i,
    input  logic    rd_clk_i,
    input  logic    rst_n_i,
    input  mac_rx_t wr_i,
    output mac_rx_t rd_o
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    typedef logic [DEPTH_LOG2:0] ptr_t;

    // gray pointers differ only in the two top bits when full
    localparam ptr_t FULL_XOR = {2'b11, {(DEPTH_LOG2-1){1'b0}}};

    mac_rx_t mem [DEPTH];
    ptr_t    wbin;
    ptr_t    wbin_nxt;
    ptr_t    wgray;
    ptr_t    rq1_gray;
    ptr_t    rq2_gray;
    ptr_t    rbin;
    ptr_t    rbin_nxt;
    ptr_t    rgray;
    ptr_t    wq1_gray;
    ptr_t    wq2_gray;
    logic    wr_en;
    logic    rd_en;
    logic    full;
    logic    empty;

    function automatic ptr_t bin2gray(input ptr_t b);
        return b ^ (b >> 1);
    endfunction

    assign full     = ((wgray ^ rq2_gray) == FULL_XOR);
    assign wr_en    = wr_i.valid & ~full;      // idle beats never stored
    assign wbin_nxt = wbin + ptr_t'(wr_en);

    always_ff @(posedge wr_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wbin     <= '0;
            wgray    <= '0;
            rq1_gray <= '0;
            rq2_gray <= '0;
        end else begin
            wbin     <= wbin_nxt;
            wgray    <= bin2gray(wbin_nxt);
            rq1_gray <= rgray;                 // read pointer into rx clock
            rq2_gray <= rq1_gray;
        end
    end

    always_ff @(posedge wr_clk_i) begin
        if (wr_en) begin
            mem[wbin[DEPTH_LOG2-1:0]] <= wr_i;
        end
    end

    assign empty    = (rgray == wq2_gray);
    assign rd_en    = ~empty;                  // pop whenever data is there
    assign rbin_nxt = rbin + ptr_t'(rd_en);

    always_ff @(posedge rd_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rbin     <= '0;
            rgray    <= '0;
            wq1_gray <= '0;
            wq2_gray <= '0;
            rd_o     <= '0;
        end else begin
            rbin     <= rbin_nxt;
            rgray    <= bin2gray(rbin_nxt);
            wq1_gray <= wgray;                 // write pointer into HCLK
            wq2_gray <= wq1_gray;
            rd_o     <= rd_en ? mem[rbin[DEPTH_LOG2-1:0]] : '0;
        end
    end

endmodule

// File: udp_tx_engine.sv
module udp_tx_engine import soc_glue_pkg::*; (
    input  logic     HCLK,
    input  logic     rst_n_i,
    input  ahb_req_t ahb_i,
    output ahb_rsp_t ahb_o,
    input  logic     mac_tpnd_i,
    output mac_tx_t  tx_o,
    output logic     udp_cs_o
);

    localparam int IDX_W = $clog2(UDP_BUF_BYTES);

    byte_t            buf_mem [UDP_BUF_BYTES];
    udp_state_e       state;
    logic             ap_sample;
    logic             ap_valid;
    logic             ap_write;
    logic [7:0]       ap_ofs;
    logic [3:0]       ap_be;
    logic [3:0]       be_next;
    logic [IDX_W:0]   len_r;
    logic [IDX_W:0]   len_wr;
    logic [IDX_W-1:0] idx;
    logic             busy;
    logic             wr_buf;
    logic             wr_ctrl;
    logic             start_send;
    logic             beat_last;
    logic             beat_acc;
    word_t            rdata;

    assign ap_sample = ahb_i.sel & ahb_i.ready & ahb_i.trans[1];

    // byte lanes from size and low address
    always_comb begin
        case (ahb_i.size)
            3'b000:  be_next = 4'b0001 << ahb_i.addr[1:0];
            3'b001:  be_next = ahb_i.addr[1] ? 4'b1100 : 4'b0011;
            default: be_next = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ap_valid <= 1'b0;
        end else begin
            ap_valid <= ap_sample;
        end
    end

    // address phase payload
    always_ff @(posedge HCLK) begin
        if (ap_sample) begin
            ap_write <= ahb_i.write;
            ap_ofs   <= ahb_i.addr[7:0];
            ap_be    <= be_next;
        end
    end

    assign busy    = (state == SEND);
    assign wr_buf  = ap_valid & ap_write & (ap_ofs[7:4] == 4'h0);
    assign wr_ctrl = ap_valid & ap_write & (ap_ofs == UDP_CTRL_OFS);
    assign len_wr  = ahb_i.wdata[IDX_W:0];

    // lengths 1 to 16 only, and only while idle
    assign start_send = wr_ctrl & ~busy & (len_wr != '0)
                      & (len_wr <= (IDX_W+1)'(UDP_BUF_BYTES));

    // frame buffer, little endian lanes
    always_ff @(posedge HCLK) begin
        if (wr_buf) begin
            for (int k = 0; k < 4; k++) begin
                if (ap_be[k]) begin
                    buf_mem[{ap_ofs[3:2], k[1:0]}] <= ahb_i.wdata[8*k +: 8];
                end
            end
        end
    end

    assign beat_last = ({1'b0, idx} == len_r - 1'b1);
    assign beat_acc  = busy & ~mac_tpnd_i;

    always_ff @(posedge HCLK or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= IDLE;
            len_r <= '0;
            idx   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_send) begin
                        state <= SEND;
                        len_r <= len_wr;
                        idx   <= '0;
                    end
                end
                SEND: begin
                    if (beat_acc) begin
                        if (beat_last) begin
                            state <= IDLE;     // cs drops next cycle
                        end else begin
                            idx <= idx + 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // beat holds while mac is pending
    assign tx_o.data  = buf_mem[idx];
    assign tx_o.start = busy & (idx == '0);
    assign tx_o.last  = busy & beat_last;
    assign udp_cs_o   = busy;

    // read data in the data phase
    always_comb begin
        rdata = '0;
        if (ap_valid && !ap_write) begin
            if (ap_ofs[7:4] == 4'h0) begin
                rdata = {buf_mem[{ap_ofs[3:2], 2'd3}], buf_mem[{ap_ofs[3:2], 2'd2}],
                         buf_mem[{ap_ofs[3:2], 2'd1}], buf_mem[{ap_ofs[3:2], 2'd0}]};
            end else if (ap_ofs == UDP_STAT_OFS) begin
                rdata = {{31{1'b0}}, busy};
            end
        end
    end

    // zero wait states, always OKAY
    assign ahb_o.readyout = 1'b1;
    assign ahb_o.resp     = 1'b0;
    assign ahb_o.rdata    = rdata;

endmodule

// File: heartbeat_led.sv
module heartbeat_led #(
    parameter int HEARTBEAT_TICKS = 33_000_000
) (
    input  logic HCLK,
    input  logic rst_key,
    output logic led_o
);

    localparam int CNT_W = $clog2(HEARTBEAT_TICKS + 1);

    logic [CNT_W-1:0] tick_cnt;
    logic             wrap;

    assign wrap = (tick_cnt == CNT_W'(HEARTBEAT_TICKS));

    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            tick_cnt <= '0;
        end else if (wrap) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // led comes out of reset lit
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            led_o <= 1'b1;
        end else if (wrap) begin
            led_o <= ~led_o;
        end
    end

endmodule

// File: sys_reset_ctrl.sv
module sys_reset_ctrl #(
    parameter int RESET_HOLD = 16
) (
    input  logic HCLK,
    input  logic rst_key,
    input  logic ddr_init_done_i,
    input  logic watchdog_reset_i,
    input  logic sys_reset_req_i,
    output logic sys_rst_n_o
);

    localparam int CNT_W = $clog2(RESET_HOLD + 1);

    logic [CNT_W-1:0] hold_cnt;
    logic             release_ok;
    logic             rst_meta;
    logic             rst_sync;

    // hold counter, reloaded by watchdog or software request
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            hold_cnt <= '0;
        end else if (watchdog_reset_i || sys_reset_req_i) begin
            hold_cnt <= CNT_W'(RESET_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // memory ready and no pending hold
    assign release_ok = ddr_init_done_i & (hold_cnt == '0);

    // two stage release synchronizer
    always_ff @(posedge HCLK or negedge rst_key) begin
        if (!rst_key) begin
            rst_meta <= 1'b0;
            rst_sync <= 1'b0;
        end else begin
            rst_meta <= release_ok;
            rst_sync <= rst_meta;
        end
    end

    assign sys_rst_n_o = rst_sync;

endmodule

// File: soc_glue_pkg.sv
package soc_glue_pkg;

    // plain vector types
    typedef logic [7:0]  byte_t;   // one mac stream byte
    typedef logic [31:0] word_t;   // ahb data word
    typedef logic [31:0] addr_t;   // ahb address

    // ahb request after slave decode
    typedef struct packed {
        logic       sel;           // region already decoded
        logic       ready;         // HREADY from the bus
        logic [1:0] trans;
        logic       write;
        logic [2:0] size;
        addr_t      addr;
        word_t      wdata;
    } ahb_req_t;

    // ahb slave response
    typedef struct packed {
        logic  readyout;
        logic  resp;               // 0 is OKAY
        word_t rdata;
    } ahb_rsp_t;

    // mac transmit beat
    typedef struct packed {
        byte_t data;
        logic  start;              // first byte of frame
        logic  last;               // final byte of frame
    } mac_tx_t;

    // mac receive word, zero when not valid
    typedef struct packed {
        logic  last;
        logic  valid;
        byte_t data;
    } mac_rx_t;

    typedef enum logic {
        IDLE,
        SEND
    } udp_state_e;

    localparam logic [3:0] UDP_REGION    = 4'h7;   // HADDR[31:28]
    localparam int         UDP_BUF_BYTES = 16;
    localparam logic [7:0] UDP_CTRL_OFS  = 8'h10;  // write starts a send
    localparam logic [7:0] UDP_STAT_OFS  = 8'h14;  // bit 0 busy

endpackage
